// ==== vlog.f ====
+incdir+dv
source/cd_xfer_pkg.sv
source/sector_loader.sv
source/sector_cache.sv
source/dma_engine.sv
source/cd_host_regs.sv
source/cd_xfer_top.sv
dv/tb_cd_xfer.sv

// ==== Makefile ====
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing -Wno-fatal
TOP = tb_cd_xfer
FILELIST = vlog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_cd_tasks.svh ====
/* Host bus, sector stream and compare tasks, included inside the
   testbench top so they drive its signals directly */
`ifndef TB_CD_TASKS_SVH
`define TB_CD_TASKS_SVH

task automatic stop_on_error(input string what);
	$display("%s", what);
	$display("Verification failed");
	$fatal(1, "run stopped at the first error");
endtask

// ==============================
// Typed compares
// ==============================
task automatic check_word(input string name, input logic [cd_xfer_pkg::WORD_W-1:0] got,
	input logic [cd_xfer_pkg::WORD_W-1:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_addr(input string name, input logic [cd_xfer_pkg::ADDR_W-1:0] got,
	input logic [cd_xfer_pkg::ADDR_W-1:0] exp);
	if (got !== exp)
		stop_on_error($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
		stop_on_error($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
endtask

// One Wishbone classic cycle, called on a falling edge
task automatic host_access(input logic we, input logic [cd_xfer_pkg::HOST_ADR_W-1:0] adr,
	input logic [cd_xfer_pkg::WORD_W-1:0] wdata, output logic [cd_xfer_pkg::WORD_W-1:0] rdata);
	int waited;
	waited = 0;
	host_cyc = 1'b1;
	host_stb = 1'b1;
	host_we = we;
	host_adr = adr;
	host_dat_w = wdata;
	@(negedge clk_sys);
	while (!host_ack)
	begin
		waited++;
		if (waited > 8)
			stop_on_error("host port gave no acknowledge");
		@(negedge clk_sys);
	end
	rdata = host_dat_r;
	host_cyc = 1'b0;
	host_stb = 1'b0;
	host_we = 1'b0;
	@(negedge clk_sys);		// stb low for a cycle before the next access
endtask

task automatic host_write(input logic [cd_xfer_pkg::HOST_ADR_W-1:0] adr,
	input logic [cd_xfer_pkg::WORD_W-1:0] data);
	logic [cd_xfer_pkg::WORD_W-1:0] unused;
	host_access(1'b1, adr, data, unused);
endtask

task automatic host_read(input logic [cd_xfer_pkg::HOST_ADR_W-1:0] adr,
	output logic [cd_xfer_pkg::WORD_W-1:0] data);
	host_access(1'b0, adr, 16'h0000, data);
endtask

// Polls the busy bit until the engine is idle
task automatic wait_dma_done(input logic expect_busy);
	logic [15:0] status;
	int polls;
	polls = 0;
	host_read(cd_xfer_pkg::REG_STATUS, status);
	check_flag("dma_busy", status[0], expect_busy);
	while (status[0])
	begin
		polls++;
		if (polls > POLL_LIMIT)
			stop_on_error("DMA stayed busy too long");
		host_read(cd_xfer_pkg::REG_STATUS, status);
	end
endtask

// Whole sector, header and data words back to back
task automatic load_sector(input int tag);
	check_flag("sector_wr_ready", sector_wr_ready, 1'b1);
	sector_download = 1'b1;
	for (int i = 0; i < STREAM_WORDS; i++)
	begin
		@(negedge clk_sys);
		sector_wr = 1'b1;
		sector_idx = cd_xfer_pkg::STREAM_IDX_W'(i);
		sector_data = stream_word(tag, i);
	end
	@(negedge clk_sys);
	sector_wr = 1'b0;
	sector_download = 1'b0;
endtask

task automatic expect_write(input logic [cd_xfer_pkg::ADDR_W-1:0] adr,
	input logic [cd_xfer_pkg::WORD_W-1:0] dat);
	if (write_adr.size() == 0)
		stop_on_error("an expected memory write never happened");
	check_addr("mem_adr", write_adr.pop_front(), adr);
	check_word("mem_dat_w", write_dat.pop_front(), dat);
endtask

task automatic check_log_empty();
	if (write_adr.size() != 0)
		stop_on_error("DMA made more memory writes than expected");
endtask

`endif

// ==== dv/tb_cd_xfer.sv ====
/* Testbench for the CD sector transfer path. Loads sectors, drives the host
   register port and checks every memory write the DMA engine makes */
`timescale 1ns/10ps

module tb_cd_xfer;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int STREAM_WORDS = int'(cd_xfer_pkg::DATA_WORD_FIRST) + cd_xfer_pkg::SECTOR_WORDS;
	localparam int FILL_UNITS = 5;
	localparam int WORD_UNITS = 8;
	localparam int BYTE_UNITS = 4;
	localparam int TAG_A = 17;
	localparam int TAG_B = 90;
	localparam int POLL_LIMIT = 2000;

	// ==============================
	// Watchdog budget
	// ==============================
	localparam int MEM_WRITES = FILL_UNITS + WORD_UNITS + 2 * BYTE_UNITS;
	localparam int WRITE_CYCLES = 12;		// Three wait states plus FSM overhead
	localparam int HOST_ACCESSES = 200;	// Setup writes, readback and status polls
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 2 * (STREAM_WORDS + 8)
		+ MEM_WRITES * WRITE_CYCLES + HOST_ACCESSES * 3);

	logic clk_sys;
	logic nRESET;
	logic sector_download;
	logic sector_wr;
	logic [cd_xfer_pkg::STREAM_IDX_W-1:0] sector_idx;
	logic [cd_xfer_pkg::WORD_W-1:0] sector_data;
	logic sector_wr_ready;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	logic [cd_xfer_pkg::HOST_ADR_W-1:0] host_adr;
	logic [cd_xfer_pkg::WORD_W-1:0] host_dat_w;
	logic [1:0] host_sel;
	logic [cd_xfer_pkg::WORD_W-1:0] host_dat_r;
	logic host_ack;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [cd_xfer_pkg::ADDR_W-1:0] mem_adr;
	logic [cd_xfer_pkg::WORD_W-1:0] mem_dat_w;
	logic [1:0] mem_sel;
	logic mem_ack;

	integer seed = 49771;
	int mem_wait;
	logic [cd_xfer_pkg::ADDR_W-1:0] write_adr [$];	// Memory write log
	logic [cd_xfer_pkg::WORD_W-1:0] write_dat [$];

	cd_xfer_top u_cd_xfer_top (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Word of the drive stream for a given sector tag
	function automatic logic [15:0] stream_word(input int tag, input int idx);
		stream_word = 16'(tag * 32'h3b1d) ^ 16'(idx * 32'h0107) ^ 16'hA55A;
	endfunction

	function automatic logic [15:0] swap_bytes(input logic [15:0] w);
		swap_bytes = {w[7:0], w[15:8]};
	endfunction

	`include "tb_cd_tasks.svh"

	// ==============================
	// Wishbone memory model
	// ==============================
	always @(negedge clk_sys)
	begin
		if (!nRESET)
		begin
			mem_ack = 1'b0;
			mem_wait = -1;
		end
		else if (mem_ack)
			mem_ack = 1'b0;		// Master drops the cycle after the ack
		else if (mem_cyc && mem_stb)
		begin
			if (mem_wait < 0)
				mem_wait = int'($unsigned($random(seed)) % 32'd4);	// 0 to 3 waits
			if (mem_wait == 0)
			begin
				check_flag("mem_we", mem_we, 1'b1);
				check_flag("mem_sel all ones", &mem_sel, 1'b1);
				write_adr.push_back(mem_adr);
				write_dat.push_back(mem_dat_w);
				mem_ack = 1'b1;
				mem_wait = -1;
			end
			else
				mem_wait = mem_wait - 1;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_on_error("watchdog expired before the tests finished");
	end

	task automatic wait_wr_ready(input logic level);
		int waited;
		waited = 0;
		while (sector_wr_ready !== level)
		begin
			waited++;
			if (waited > 16)
				stop_on_error("sector_wr_ready did not reach the expected level");
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_sector_ready(input logic level);
		logic [15:0] status;
		int polls;
		polls = 0;
		host_read(cd_xfer_pkg::REG_STATUS, status);
		while (status[1] !== level)
		begin
			polls++;
			if (polls > 16)
				stop_on_error("sector ready status bit did not reach the expected level");
			host_read(cd_xfer_pkg::REG_STATUS, status);
		end
	endtask

	task automatic start_dma(input logic [23:0] adr, input logic [15:0] units,
		input logic [15:0] ucode, input logic [15:0] value);
		host_write(cd_xfer_pkg::REG_ADDR_A_HI, {8'h00, adr[23:16]});
		host_write(cd_xfer_pkg::REG_ADDR_A_LO, adr[15:0]);
		host_write(cd_xfer_pkg::REG_COUNT_HI, 16'h0000);
		host_write(cd_xfer_pkg::REG_COUNT_LO, units);
		host_write(cd_xfer_pkg::REG_VALUE_HI, value);
		host_write(cd_xfer_pkg::REG_UCODE0, ucode);
		host_write(cd_xfer_pkg::REG_CTRL, 16'h0040);	// Start bit
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_reset_state();
		logic [15:0] rd;
		check_flag("host_ack", host_ack, 1'b0);
		check_flag("mem_cyc", mem_cyc, 1'b0);
		check_flag("mem_stb", mem_stb, 1'b0);
		check_flag("sector_wr_ready", sector_wr_ready, 1'b1);
		host_read(cd_xfer_pkg::REG_STATUS, rd);
		check_word("status", rd, 16'h0000);
	endtask

	task automatic test_register_readback();
		logic [15:0] rd;
		host_write(cd_xfer_pkg::REG_ADDR_A_HI, 16'h00A5);
		host_write(cd_xfer_pkg::REG_ADDR_A_LO, 16'h1234);
		host_write(cd_xfer_pkg::REG_COUNT_HI, 16'h0001);
		host_write(cd_xfer_pkg::REG_COUNT_LO, 16'hFEDC);
		host_write(cd_xfer_pkg::REG_VALUE_HI, 16'h5AA5);
		host_read(cd_xfer_pkg::REG_ADDR_A_HI, rd);
		check_word("addr_a_hi", rd, 16'h00A5);
		host_read(cd_xfer_pkg::REG_ADDR_A_LO, rd);
		check_word("addr_a_lo", rd, 16'h1234);
		host_read(cd_xfer_pkg::REG_COUNT_HI, rd);
		check_word("count_hi", rd, 16'h0001);
		host_read(cd_xfer_pkg::REG_COUNT_LO, rd);
		check_word("count_lo", rd, 16'hFEDC);
		host_read(cd_xfer_pkg::REG_VALUE_HI, rd);
		check_word("value_hi", rd, 16'h5AA5);
		host_read(9'h040, rd);		// Unmapped
		check_word("unmapped", rd, 16'h0000);
	endtask

	task automatic test_fill();
		start_dma(24'h008000, 16'(FILL_UNITS), cd_xfer_pkg::UCODE_FILL_A, 16'hBEEF);
		wait_dma_done(1'b1);
		for (int i = 0; i < FILL_UNITS; i++)
			expect_write(24'h008000 + 24'(2 * i), 16'hBEEF);
		check_log_empty();
	endtask

	task automatic test_unknown_ucode();
		start_dma(24'h00C000, 16'd3, 16'h1234, 16'h0000);
		wait_dma_done(1'b0);
		repeat (8) @(negedge clk_sys);
		check_log_empty();
	endtask

	task automatic test_sector_header();
		logic [15:0] rd;
		load_sector(TAG_A);
		wait_sector_ready(1'b1);
		host_read(cd_xfer_pkg::REG_HEADER_LO, rd);
		check_word("header_lo", rd, stream_word(TAG_A, 6));
		host_read(cd_xfer_pkg::REG_HEADER_HI, rd);
		check_word("header_hi", rd, stream_word(TAG_A, 7));
	endtask

	// Second sector goes into the other bank, both banks full
	task automatic test_double_buffer();
		logic [15:0] rd;
		load_sector(TAG_B);
		wait_wr_ready(1'b0);
		host_read(cd_xfer_pkg::REG_STATUS, rd);
		check_flag("sector_ready", rd[1], 1'b1);
		host_read(cd_xfer_pkg::REG_HEADER_LO, rd);
		check_word("header_lo", rd, stream_word(TAG_A, 6));
	endtask

	task automatic test_word_copy();
		logic [15:0] rd;
		start_dma(24'h3A1000, 16'(WORD_UNITS), cd_xfer_pkg::UCODE_CD_WORD_A, 16'h0000);
		wait_dma_done(1'b1);
		for (int i = 0; i < WORD_UNITS; i++)
			expect_write(24'h3A1000 + 24'(2 * i), stream_word(TAG_A, i + 8));
		check_log_empty();
		wait_wr_ready(1'b1);		// Released bank frees the loader
		host_read(cd_xfer_pkg::REG_STATUS, rd);
		check_flag("sector_ready", rd[1], 1'b1);
		host_read(cd_xfer_pkg::REG_HEADER_LO, rd);
		check_word("header_lo", rd, stream_word(TAG_B, 6));
	endtask

	task automatic test_byte_copy();
		logic [15:0] w;
		start_dma(24'h200100, 16'(BYTE_UNITS), cd_xfer_pkg::UCODE_CD_BYTE, 16'h0000);
		wait_dma_done(1'b1);
		for (int i = 0; i < BYTE_UNITS; i++)
		begin
			w = stream_word(TAG_B, i + 8);
			expect_write(24'h200100 + 24'(4 * i), swap_bytes(w));
			expect_write(24'h200102 + 24'(4 * i), w);
		end
		check_log_empty();
		wait_sector_ready(1'b0);	// No sector left
		check_flag("sector_wr_ready", sector_wr_ready, 1'b1);
	endtask

	initial
	begin
		clk_sys = 1'b0;
		nRESET = 1'b0;
		sector_download = 1'b0;
		sector_wr = 1'b0;
		sector_idx = '0;
		sector_data = '0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		host_sel = 2'b11;
		mem_ack = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		nRESET = 1'b1;
		@(negedge clk_sys);

		test_reset_state();
		test_register_readback();
		test_fill();
		test_unknown_ucode();
		test_sector_header();
		test_double_buffer();
		test_word_copy();
		test_byte_copy();

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== source/cd_xfer_top.sv ====
/* Top level of the CD sector transfer path. Drive stream in, host
   registers on one Wishbone port, memory writes on another */
`timescale 1ns/10ps

module cd_xfer_top
(
	input  logic clk_sys,
	input  logic nRESET,
	// Sector stream from the drive side
	input  logic sector_download,
	input  logic sector_wr,
	input  logic [cd_xfer_pkg::STREAM_IDX_W-1:0] sector_idx,
	input  logic [cd_xfer_pkg::WORD_W-1:0] sector_data,
	output logic sector_wr_ready,
	// Host port
	input  logic host_cyc,
	input  logic host_stb,
	input  logic host_we,
	input  logic [cd_xfer_pkg::HOST_ADR_W-1:0] host_adr,
	input  logic [cd_xfer_pkg::WORD_W-1:0] host_dat_w,
	input  logic [1:0] host_sel,
	output logic [cd_xfer_pkg::WORD_W-1:0] host_dat_r,
	output logic host_ack,
	// Memory port
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [cd_xfer_pkg::ADDR_W-1:0] mem_adr,
	output logic [cd_xfer_pkg::WORD_W-1:0] mem_dat_w,
	output logic [1:0] mem_sel,
	input  logic mem_ack
);

	// Loader to cache
	logic cache_wr;
	logic [cd_xfer_pkg::CACHE_IDX_W-1:0] cache_wr_idx;
	logic [cd_xfer_pkg::WORD_W-1:0] cache_wr_data;
	logic header_wr;
	logic [cd_xfer_pkg::WORD_W-1:0] header_lo;
	logic [cd_xfer_pkg::WORD_W-1:0] header_hi;
	logic load_done;

	// Cache to DMA and registers
	logic [cd_xfer_pkg::CACHE_IDX_W-1:0] rd_idx;
	logic [cd_xfer_pkg::WORD_W-1:0] rd_data;
	logic rd_release;
	logic sector_ready;
	logic [cd_xfer_pkg::WORD_W-1:0] rd_header_lo;
	logic [cd_xfer_pkg::WORD_W-1:0] rd_header_hi;

	// Registers to DMA
	logic dma_start;
	logic dma_busy;
	cd_xfer_pkg::dma_mode_t dma_mode;
	logic [cd_xfer_pkg::ADDR_W-1:0] addr_a;
	logic [cd_xfer_pkg::WORD_W-1:0] fill_value;
	logic [31:0] count;

	sector_loader u_sector_loader
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.sector_download(sector_download), .sector_wr(sector_wr),
		.sector_idx(sector_idx), .sector_data(sector_data),
		.wr_bank_free(sector_wr_ready),
		.cache_wr(cache_wr), .cache_wr_idx(cache_wr_idx), .cache_wr_data(cache_wr_data),
		.header_wr(header_wr), .header_lo(header_lo), .header_hi(header_hi),
		.load_done(load_done)
	);

	sector_cache u_sector_cache
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cache_wr(cache_wr), .cache_wr_idx(cache_wr_idx), .cache_wr_data(cache_wr_data),
		.header_wr(header_wr), .header_lo(header_lo), .header_hi(header_hi),
		.load_done(load_done), .rd_idx(rd_idx), .rd_release(rd_release),
		.rd_data(rd_data), .wr_bank_free(sector_wr_ready), .sector_ready(sector_ready),
		.rd_header_lo(rd_header_lo), .rd_header_hi(rd_header_hi)
	);

	cd_host_regs u_cd_host_regs
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
		.host_adr(host_adr), .host_dat_w(host_dat_w), .host_sel(host_sel),
		.dma_busy(dma_busy), .sector_ready(sector_ready),
		.rd_header_lo(rd_header_lo), .rd_header_hi(rd_header_hi),
		.host_dat_r(host_dat_r), .host_ack(host_ack),
		.dma_start(dma_start), .dma_mode(dma_mode), .addr_a(addr_a),
		.fill_value(fill_value), .count(count)
	);

	dma_engine u_dma_engine
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.dma_start(dma_start), .dma_mode(dma_mode), .addr_a(addr_a),
		.fill_value(fill_value), .count(count), .rd_data(rd_data), .mem_ack(mem_ack),
		.dma_busy(dma_busy), .rd_idx(rd_idx), .rd_release(rd_release),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
		.mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_sel(mem_sel)
	);

endmodule

// ==== source/cd_host_regs.sv ====
/* Host register block on a Wishbone classic slave port. Holds the DMA
   settings, decodes the microcode and reports status and sector header */
`timescale 1ns/10ps

module cd_host_regs
(
	input  logic clk_sys,
	input  logic nRESET,
	input  logic host_cyc,
	input  logic host_stb,
	input  logic host_we,
	input  logic [cd_xfer_pkg::HOST_ADR_W-1:0] host_adr,
	input  logic [cd_xfer_pkg::WORD_W-1:0] host_dat_w,
	input  logic [1:0] host_sel,
	input  logic dma_busy,
	input  logic sector_ready,
	input  logic [cd_xfer_pkg::WORD_W-1:0] rd_header_lo,
	input  logic [cd_xfer_pkg::WORD_W-1:0] rd_header_hi,
	output logic [cd_xfer_pkg::WORD_W-1:0] host_dat_r,
	output logic host_ack,
	output logic dma_start,
	output cd_xfer_pkg::dma_mode_t dma_mode,
	output logic [cd_xfer_pkg::ADDR_W-1:0] addr_a,
	output logic [cd_xfer_pkg::WORD_W-1:0] fill_value,
	output logic [31:0] count
);

	logic req;
	logic served;		// Acked, waiting for stb to drop
	logic access;
	logic [cd_xfer_pkg::WORD_W-1:0] ucode0;
	logic [cd_xfer_pkg::WORD_W-1:0] rd_word;
	cd_xfer_pkg::dma_mode_t ucode_mode;

	assign req = host_cyc & host_stb;
	assign access = req & ~host_ack & ~served;

	// Byte lane merge for partial writes
	function automatic logic [15:0] merge(input logic [15:0] old_w,
		input logic [15:0] new_w, input logic [1:0] sel);
		merge = {sel[1] ? new_w[15:8] : old_w[15:8], sel[0] ? new_w[7:0] : old_w[7:0]};
	endfunction

	always_comb
	begin
		case (ucode0)
			cd_xfer_pkg::UCODE_CD_WORD_A, cd_xfer_pkg::UCODE_CD_WORD_B:
				ucode_mode = cd_xfer_pkg::DMA_CD_WORD;
			cd_xfer_pkg::UCODE_CD_BYTE: ucode_mode = cd_xfer_pkg::DMA_CD_BYTE;
			cd_xfer_pkg::UCODE_FILL_A, cd_xfer_pkg::UCODE_FILL_B:
				ucode_mode = cd_xfer_pkg::DMA_FILL;
			default: ucode_mode = cd_xfer_pkg::DMA_NONE;	// Unknown program
		endcase
	end

	// ==============================
	// Bus handshake and writes
	// ==============================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			host_ack <= 1'b0;
			served <= 1'b0;
			dma_start <= 1'b0;
			dma_mode <= cd_xfer_pkg::DMA_NONE;
			addr_a <= '0;
			fill_value <= '0;
			count <= '0;
			ucode0 <= '0;
		end
		else
		begin
			host_ack <= access;
			dma_start <= 1'b0;
			if (!req)
				served <= 1'b0;
			else if (host_ack)
				served <= 1'b1;

			if (access && host_we)
			begin
				case (host_adr)
					cd_xfer_pkg::REG_CTRL:
						if (host_sel[0] && host_dat_w[cd_xfer_pkg::CTRL_START_BIT])
						begin
							dma_mode <= ucode_mode;
							dma_start <= (ucode_mode != cd_xfer_pkg::DMA_NONE) && !dma_busy;
						end
					cd_xfer_pkg::REG_ADDR_A_HI:
						if (host_sel[0])
							addr_a[23:16] <= host_dat_w[7:0];
					cd_xfer_pkg::REG_ADDR_A_LO: addr_a[15:0] <= merge(addr_a[15:0], host_dat_w, host_sel);
					cd_xfer_pkg::REG_VALUE_HI: fill_value <= merge(fill_value, host_dat_w, host_sel);
					cd_xfer_pkg::REG_COUNT_HI: count[31:16] <= merge(count[31:16], host_dat_w, host_sel);
					cd_xfer_pkg::REG_COUNT_LO: count[15:0] <= merge(count[15:0], host_dat_w, host_sel);
					cd_xfer_pkg::REG_UCODE0: ucode0 <= merge(ucode0, host_dat_w, host_sel);
					default: ;
				endcase
			end
		end
	end

	// Readback, odd and unmapped offsets give zero
	always_comb
	begin
		case (host_adr)
			cd_xfer_pkg::REG_STATUS: rd_word = {14'd0, sector_ready, dma_busy};
			cd_xfer_pkg::REG_ADDR_A_HI: rd_word = {8'd0, addr_a[23:16]};
			cd_xfer_pkg::REG_ADDR_A_LO: rd_word = addr_a[15:0];
			cd_xfer_pkg::REG_VALUE_HI: rd_word = fill_value;
			cd_xfer_pkg::REG_COUNT_HI: rd_word = count[31:16];
			cd_xfer_pkg::REG_COUNT_LO: rd_word = count[15:0];
			cd_xfer_pkg::REG_UCODE0: rd_word = ucode0;
			cd_xfer_pkg::REG_HEADER_LO: rd_word = rd_header_lo;
			cd_xfer_pkg::REG_HEADER_HI: rd_word = rd_header_hi;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (access)
			host_dat_r <= rd_word;	// Valid together with ack
	end

endmodule

// ==== source/dma_engine.sv ====
/* DMA engine. Copies the read bank of the sector cache into system memory
   or fills memory with a constant, writing through a Wishbone master */
`timescale 1ns/10ps

module dma_engine
(
	input  logic clk_sys,
	input  logic nRESET,
	input  logic dma_start,
	input  cd_xfer_pkg::dma_mode_t dma_mode,
	input  logic [cd_xfer_pkg::ADDR_W-1:0] addr_a,
	input  logic [cd_xfer_pkg::WORD_W-1:0] fill_value,
	input  logic [31:0] count,
	input  logic [cd_xfer_pkg::WORD_W-1:0] rd_data,
	input  logic mem_ack,
	output logic dma_busy,
	output logic [cd_xfer_pkg::CACHE_IDX_W-1:0] rd_idx,
	output logic rd_release,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [cd_xfer_pkg::ADDR_W-1:0] mem_adr,
	output logic [cd_xfer_pkg::WORD_W-1:0] mem_dat_w,
	output logic [1:0] mem_sel
);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_CHECK,	// Units left?
		ST_RD,		// Cache word arrives
		ST_WR,		// Bus cycle open until ack
		ST_GAP,		// Bus idle between the two byte copy writes
		ST_NEXT
	} dma_state_t;

	dma_state_t state;
	cd_xfer_pkg::dma_mode_t mode;
	logic [31:0] remaining;
	logic bus_req;
	logic second;		// Second write of a byte copy unit done
	logic cache_mode;

	assign cache_mode = (mode == cd_xfer_pkg::DMA_CD_WORD) || (mode == cd_xfer_pkg::DMA_CD_BYTE);

	assign mem_cyc = bus_req;
	assign mem_stb = bus_req;
	assign mem_we = 1'b1;
	assign mem_sel = 2'b11;

	// ==============================
	// Control FSM
	// ==============================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= ST_IDLE;
			mode <= cd_xfer_pkg::DMA_NONE;
			dma_busy <= 1'b0;
			bus_req <= 1'b0;
			rd_release <= 1'b0;
			second <= 1'b0;
		end
		else
		begin
			rd_release <= 1'b0;
			case (state)
				ST_IDLE:
					if (dma_start)
					begin
						mode <= dma_mode;
						dma_busy <= 1'b1;
						state <= ST_CHECK;
					end
				ST_CHECK:
					if (remaining == 32'd0)
					begin
						dma_busy <= 1'b0;
						rd_release <= cache_mode;	// Hand the bank back
						state <= ST_IDLE;
					end
					else if (cache_mode)
						state <= ST_RD;
					else
					begin
						bus_req <= 1'b1;	// Fill goes straight to the bus
						state <= ST_WR;
					end
				ST_RD:
				begin
					second <= 1'b0;
					bus_req <= 1'b1;
					state <= ST_WR;
				end
				ST_WR:
					if (mem_ack)
					begin
						bus_req <= 1'b0;
						if (mode == cd_xfer_pkg::DMA_CD_BYTE && !second)
						begin
							second <= 1'b1;
							state <= ST_GAP;
						end
						else
							state <= ST_NEXT;
					end
				ST_GAP:
				begin
					bus_req <= 1'b1;
					state <= ST_WR;
				end
				ST_NEXT: state <= ST_CHECK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address, data and counters
	always_ff @(posedge clk_sys)
	begin
		case (state)
			ST_IDLE:
				if (dma_start)
				begin
					mem_adr <= addr_a;
					mem_dat_w <= fill_value;	// Stays put for the whole fill
					remaining <= count;
					rd_idx <= '0;
				end
			ST_RD:
				if (mode == cd_xfer_pkg::DMA_CD_BYTE)
					mem_dat_w <= {rd_data[7:0], rd_data[15:8]};
				else
					mem_dat_w <= rd_data;
			ST_WR:
				if (mem_ack)
					mem_adr <= mem_adr + 24'd2;
			ST_GAP:
				mem_dat_w <= {mem_dat_w[7:0], mem_dat_w[15:8]};	// Back to the word as read
			ST_NEXT:
			begin
				remaining <= remaining - 32'd1;
				rd_idx <= rd_idx + 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/sector_cache.sv ====
/* Two-bank sector cache. One bank is read by the DMA while the other is
   loaded, and the banks swap once the read bank is released */
`timescale 1ns/10ps

module sector_cache
(
	input  logic clk_sys,
	input  logic nRESET,
	input  logic cache_wr,
	input  logic [cd_xfer_pkg::CACHE_IDX_W-1:0] cache_wr_idx,
	input  logic [cd_xfer_pkg::WORD_W-1:0] cache_wr_data,
	input  logic header_wr,
	input  logic [cd_xfer_pkg::WORD_W-1:0] header_lo,
	input  logic [cd_xfer_pkg::WORD_W-1:0] header_hi,
	input  logic load_done,
	input  logic [cd_xfer_pkg::CACHE_IDX_W-1:0] rd_idx,
	input  logic rd_release,
	output logic [cd_xfer_pkg::WORD_W-1:0] rd_data,
	output logic wr_bank_free,
	output logic sector_ready,
	output logic [cd_xfer_pkg::WORD_W-1:0] rd_header_lo,
	output logic [cd_xfer_pkg::WORD_W-1:0] rd_header_hi
);

	logic [cd_xfer_pkg::WORD_W-1:0] mem [2*cd_xfer_pkg::SECTOR_WORDS];
	logic [cd_xfer_pkg::WORD_W-1:0] hdr_lo_mem [2];
	logic [cd_xfer_pkg::WORD_W-1:0] hdr_hi_mem [2];
	logic [1:0] filled;		// One flag per bank
	logic rd_bank;
	logic wr_bank;

	assign wr_bank = ~rd_bank;	// Loader always gets the other bank
	assign wr_bank_free = ~filled[wr_bank];
	assign sector_ready = filled[rd_bank];
	assign rd_header_lo = hdr_lo_mem[rd_bank];
	assign rd_header_hi = hdr_hi_mem[rd_bank];

	// Word memory, registered read
	always_ff @(posedge clk_sys)
	begin
		if (cache_wr)
			mem[{wr_bank, cache_wr_idx}] <= cache_wr_data;
		rd_data <= mem[{rd_bank, rd_idx}];
		if (header_wr)
		begin
			hdr_lo_mem[wr_bank] <= header_lo;
			hdr_hi_mem[wr_bank] <= header_hi;
		end
	end

	// ==============================
	// Bank flags and swapping
	// ==============================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			filled <= 2'b00;
			rd_bank <= 1'b0;
		end
		else
		begin
			if (load_done)
				filled[wr_bank] <= 1'b1;
			if (rd_release)
				filled[rd_bank] <= 1'b0;	// Copy done, bank may be reused

			// Empty read bank and a full one waiting
			if (!filled[rd_bank] && filled[wr_bank])
				rd_bank <= ~rd_bank;
		end
	end

endmodule

// ==== source/sector_loader.sv ====
/* Sector stream loader. Picks the header out of the drive word stream and
   writes the data words of one sector into the free cache bank */
`timescale 1ns/10ps

module sector_loader
(
	input  logic clk_sys,
	input  logic nRESET,
	input  logic sector_download,
	input  logic sector_wr,
	input  logic [cd_xfer_pkg::STREAM_IDX_W-1:0] sector_idx,
	input  logic [cd_xfer_pkg::WORD_W-1:0] sector_data,
	input  logic wr_bank_free,
	output logic cache_wr,
	output logic [cd_xfer_pkg::CACHE_IDX_W-1:0] cache_wr_idx,
	output logic [cd_xfer_pkg::WORD_W-1:0] cache_wr_data,
	output logic header_wr,
	output logic [cd_xfer_pkg::WORD_W-1:0] header_lo,
	output logic [cd_xfer_pkg::WORD_W-1:0] header_hi,
	output logic load_done
);

	typedef enum logic [1:0] {ST_IDLE, ST_HDR_HI, ST_DATA, ST_DONE} load_state_t;

	load_state_t state;
	logic [cd_xfer_pkg::STREAM_IDX_W-1:0] data_idx;
	logic hdr_lo_hit;
	logic hdr_hi_hit;
	logic data_hit;
	logic last_hit;

	assign data_idx = sector_idx - cd_xfer_pkg::DATA_WORD_FIRST;
	assign hdr_lo_hit = sector_download & sector_wr & (sector_idx == cd_xfer_pkg::HEADER_WORD_LO);
	assign hdr_hi_hit = sector_wr & (sector_idx == cd_xfer_pkg::HEADER_WORD_HI);

	// Top bit set means below the first data word or past the last one
	assign data_hit = sector_wr & ~data_idx[cd_xfer_pkg::STREAM_IDX_W-1];
	assign last_hit = data_hit & (data_idx[cd_xfer_pkg::CACHE_IDX_W-1:0] == cd_xfer_pkg::CACHE_IDX_LAST);

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= ST_IDLE;
			cache_wr <= 1'b0;
			header_wr <= 1'b0;
			load_done <= 1'b0;
		end
		else
		begin
			cache_wr <= 1'b0;
			header_wr <= 1'b0;
			load_done <= 1'b0;
			case (state)
				ST_IDLE:
					if (hdr_lo_hit && wr_bank_free)
						state <= ST_HDR_HI;
				ST_HDR_HI:
					if (!sector_download)
						state <= ST_DONE;	// Cut short
					else if (hdr_hi_hit)
					begin
						header_wr <= 1'b1;
						state <= ST_DATA;
					end
				ST_DATA:
					if (!sector_download)
						state <= ST_DONE;	// Bank is closed with what it holds
					else
					begin
						cache_wr <= data_hit;
						if (last_hit)
							state <= ST_DONE;
					end
				ST_DONE:
				begin
					load_done <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Header words and the word going to the cache
	always_ff @(posedge clk_sys)
	begin
		if (state == ST_IDLE && hdr_lo_hit)
			header_lo <= sector_data;
		if (state == ST_HDR_HI && hdr_hi_hit)
			header_hi <= sector_data;
		if (data_hit)
		begin
			cache_wr_idx <= data_idx[cd_xfer_pkg::CACHE_IDX_W-1:0];
			cache_wr_data <= sector_data;
		end
	end

endmodule

// ==== source/cd_xfer_pkg.sv ====
/* Constants and types shared by the CD sector transfer blocks
   Referenced by scoped names from every RTL file */
package cd_xfer_pkg;

	// ==============================
	// Data path geometry
	// ==============================
	localparam int WORD_W = 16;
	localparam int ADDR_W = 24;		// Byte address into system memory
	localparam int SECTOR_WORDS = 1024;
	localparam int STREAM_IDX_W = 11;
	localparam int CACHE_IDX_W = 10;
	localparam int HOST_ADR_W = 9;

	// Word positions inside the drive stream
	localparam logic [STREAM_IDX_W-1:0] HEADER_WORD_LO = 11'd6;
	localparam logic [STREAM_IDX_W-1:0] HEADER_WORD_HI = 11'd7;
	localparam logic [STREAM_IDX_W-1:0] DATA_WORD_FIRST = 11'd8;
	localparam logic [CACHE_IDX_W-1:0] CACHE_IDX_LAST = CACHE_IDX_W'(SECTOR_WORDS - 1);

	// ==============================
	// Host register map
	// ==============================
	localparam logic [HOST_ADR_W-1:0] REG_HEADER_LO = 9'h010;
	localparam logic [HOST_ADR_W-1:0] REG_HEADER_HI = 9'h012;
	localparam logic [HOST_ADR_W-1:0] REG_CTRL = 9'h060;
	localparam logic [HOST_ADR_W-1:0] REG_STATUS = 9'h062;	// Bit 0 busy, bit 1 sector ready
	localparam logic [HOST_ADR_W-1:0] REG_ADDR_A_HI = 9'h064;
	localparam logic [HOST_ADR_W-1:0] REG_ADDR_A_LO = 9'h066;
	localparam logic [HOST_ADR_W-1:0] REG_VALUE_HI = 9'h06C;
	localparam logic [HOST_ADR_W-1:0] REG_COUNT_HI = 9'h070;
	localparam logic [HOST_ADR_W-1:0] REG_COUNT_LO = 9'h072;
	localparam logic [HOST_ADR_W-1:0] REG_UCODE0 = 9'h07E;

	localparam int CTRL_START_BIT = 6;

	// ==============================
	// DMA microcode and modes
	// ==============================
	localparam logic [WORD_W-1:0] UCODE_CD_WORD_A = 16'hFF89;
	localparam logic [WORD_W-1:0] UCODE_CD_WORD_B = 16'hFFC5;
	localparam logic [WORD_W-1:0] UCODE_CD_BYTE = 16'hFC2D;
	localparam logic [WORD_W-1:0] UCODE_FILL_A = 16'hFFCD;
	localparam logic [WORD_W-1:0] UCODE_FILL_B = 16'hFFDD;

	typedef enum logic [2:0]
	{
		DMA_NONE = 3'd0,
		DMA_CD_WORD = 3'd1,		// Cache words straight to memory
		DMA_CD_BYTE = 3'd2,		// Swapped word, then the word itself
		DMA_FILL = 3'd3
	} dma_mode_t;

endpackage
